// ==== source/npuIssuePkg.sv ====
// NPU issue pipeline definitions
`default_nettype none

package npuIssuePkg;

	// Datapath widths
	localparam int dataW = 32;
	localparam int addrW = 32;
	localparam int regAddrW = 4;
	localparam int immW = 16;

	// Byte step between consecutive instruction words
	localparam int instrStep = 4;

	// Instruction word fields
	localparam int opMsb = 31;
	localparam int opLsb = 28;
	localparam int rdMsb = 27;
	localparam int rdLsb = 24;
	localparam int rsMsb = 23;
	localparam int rsLsb = 20;
	localparam int immMsb = 15;
	localparam int immLsb = 0;

	// Unlisted encodings execute as no-ops
	typedef enum logic [3:0] {
		opNop = 4'd0,
		opLi = 4'd1,
		opAddi = 4'd2,
		opCfg = 4'd3,
		opEnq = 4'd4,
		opDeq = 4'd5,
		opHalt = 4'd15
	} opcodeT;

	// Fetch stage payload
	typedef struct packed {
		logic [dataW-1:0] word;
	} fetchWordT;

	// Execute stage payload
	typedef struct packed {
		opcodeT op;
		logic [regAddrW-1:0] rd;
		logic [dataW-1:0] operand;
		logic [dataW-1:0] imm;
	} decodedOpT;

endpackage

`default_nettype wire

// ==== source/instrFetch.sv ====
// Instruction fetch unit
`timescale 1ns/1ps
`default_nettype none

module instrFetch #(
	parameter logic [npuIssuePkg::addrW-1:0] bootAddr = '0
) (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic halted,
	input logic [npuIssuePkg::dataW-1:0] instrData,
	input logic instrReady,
	output logic [npuIssuePkg::addrW-1:0] instrAddr,
	output logic instrValid,
	output logic fetchValid,
	output npuIssuePkg::fetchWordT fetchWord
);

	import npuIssuePkg::*;

	logic [addrW-1:0] pc;
	logic accept;

	// Request stays up until the HALT is decoded
	assign instrValid = !halted;

	// Ready during a stall does not count
	assign accept = instrValid && instrReady && !stall;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= bootAddr;
		end else if (accept) begin
			pc <= pc + addrW'(instrStep);
		end
	end

	assign instrAddr = pc;

	// Accepted word goes straight into the fetch stage register
	assign fetchValid = accept;
	assign fetchWord.word = instrData;

endmodule

`default_nettype wire

// ==== source/pipeStage.sv ====
// Pipeline stage register
`timescale 1ns/1ps
`default_nettype none

module pipeStage #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic inValid,
	input payloadT inData,
	output logic outValid,
	output payloadT outData
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			outValid <= 1'b0;
		end else if (!stall) begin
			outValid <= inValid;
		end
	end

	// Payload freezes together with the valid bit
	always_ff @(posedge clk) begin
		if (!stall) begin
			outData <= inData;
		end
	end

endmodule

`default_nettype wire

// ==== source/decodeUnit.sv ====
// Instruction decode and register file
`timescale 1ns/1ps
`default_nettype none

module decodeUnit (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic inValid,
	input npuIssuePkg::fetchWordT inWord,
	input logic wbEn,
	input logic [npuIssuePkg::regAddrW-1:0] wbAddr,
	input logic [npuIssuePkg::dataW-1:0] wbData,
	output logic opValid,
	output npuIssuePkg::decodedOpT op,
	output logic halted
);

	import npuIssuePkg::*;

	logic [dataW-1:0] regFile [2**regAddrW];

	opcodeT opcode;
	logic [regAddrW-1:0] rdField;
	logic [regAddrW-1:0] rsField;
	logic [immW-1:0] immField;
	logic [dataW-1:0] rsValue;
	logic haltSeen;

	// Field split
	assign opcode = opcodeT'(inWord.word[opMsb:opLsb]);
	assign rdField = inWord.word[rdMsb:rdLsb];
	assign rsField = inWord.word[rsMsb:rsLsb];
	assign immField = inWord.word[immMsb:immLsb];

	// Execute is the only writer
	always_ff @(posedge clk) begin
		if (wbEn) begin
			regFile[wbAddr] <= wbData;
		end
	end

	// Same-cycle writeback overrides the stored value
	always_comb begin
		if (wbEn && wbAddr == rsField) begin
			rsValue = wbData;
		end else begin
			rsValue = regFile[rsField];
		end
	end

	assign op.op = opcode;
	assign op.rd = rdField;
	assign op.operand = rsValue;
	assign op.imm = {{(dataW - immW){1'b0}}, immField};

	// HALT only counts once it leaves decode
	assign haltSeen = inValid && !halted && opcode == opHalt && !stall;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			halted <= 1'b0;
		end else if (haltSeen) begin
			halted <= 1'b1;
		end
	end

	// Words behind the HALT are dropped
	assign opValid = inValid && !halted;

endmodule

`default_nettype wire

// ==== source/npuExecute.sv ====
// Execute unit with coprocessor FIFO access
`timescale 1ns/1ps
`default_nettype none

module npuExecute (
	input logic clk,
	input logic rst_n,
	input logic opValid,
	input npuIssuePkg::decodedOpT op,
	input logic npuCfgFull,
	input logic npuInFull,
	input logic [npuIssuePkg::dataW-1:0] npuOutData,
	input logic npuOutEmpty,
	output logic stall,
	output logic [npuIssuePkg::dataW-1:0] npuCfgData,
	output logic npuCfgWe,
	output logic [npuIssuePkg::dataW-1:0] npuInData,
	output logic npuInWe,
	output logic npuOutRe,
	output logic wbEn,
	output logic [npuIssuePkg::regAddrW-1:0] wbAddr,
	output logic [npuIssuePkg::dataW-1:0] wbData,
	output logic halt
);

	import npuIssuePkg::*;

	logic isCfg;
	logic isEnq;
	logic isDeq;
	logic execFire;
	logic [dataW-1:0] sum;

	assign isCfg = opValid && op.op == opCfg;
	assign isEnq = opValid && op.op == opEnq;
	assign isDeq = opValid && op.op == opDeq;

	// A blocked FIFO freezes the whole pipeline
	assign stall = (isCfg && npuCfgFull) || (isEnq && npuInFull) || (isDeq && npuOutEmpty);

	assign execFire = opValid && !stall;

	// Strobes are one cycle per executed op
	assign npuCfgWe = isCfg && execFire;
	assign npuCfgData = op.imm;
	assign npuInWe = isEnq && execFire;
	assign npuInData = op.operand;
	assign npuOutRe = isDeq && execFire;

	// Wraps at 32 bits
	assign sum = op.operand + op.imm;

	always_comb begin
		case (op.op)
			opAddi: wbData = sum;
			opDeq: wbData = npuOutData;
			default: wbData = op.imm;
		endcase
	end

	assign wbEn = execFire && (op.op inside {opLi, opAddi, opDeq});
	assign wbAddr = op.rd;

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			halt <= 1'b0;
		end else if (execFire && op.op == opHalt) begin
			halt <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/npuIssueCore.sv ====
// NPU issue core top level
`timescale 1ns/1ps
`default_nettype none

module npuIssueCore #(
	parameter logic [npuIssuePkg::addrW-1:0] bootAddr = '0
) (
	input logic clk,
	input logic rst_n,
	output logic [npuIssuePkg::addrW-1:0] instrAddr,
	output logic instrValid,
	input logic [npuIssuePkg::dataW-1:0] instrData,
	input logic instrReady,
	output logic [npuIssuePkg::dataW-1:0] npuCfgData,
	output logic npuCfgWe,
	input logic npuCfgFull,
	output logic [npuIssuePkg::dataW-1:0] npuInData,
	output logic npuInWe,
	input logic npuInFull,
	input logic [npuIssuePkg::dataW-1:0] npuOutData,
	input logic npuOutEmpty,
	output logic npuOutRe,
	output logic halt
);

	import npuIssuePkg::*;

	logic stall;
	logic halted;
	logic fetchValid;
	fetchWordT fetchWord;
	logic fsValid;
	fetchWordT fsWord;
	logic decValid;
	decodedOpT decOp;
	logic exValid;
	decodedOpT exOp;
	logic wbEn;
	logic [regAddrW-1:0] wbAddr;
	logic [dataW-1:0] wbData;

	instrFetch #(
		.bootAddr(bootAddr)
	) i_instrFetch (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.halted(halted),
		.instrData(instrData),
		.instrReady(instrReady),
		.instrAddr(instrAddr),
		.instrValid(instrValid),
		.fetchValid(fetchValid),
		.fetchWord(fetchWord)
	);

	// Fetch stage
	pipeStage #(
		.payloadT(fetchWordT)
	) i_fetchStage (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.inValid(fetchValid),
		.inData(fetchWord),
		.outValid(fsValid),
		.outData(fsWord)
	);

	decodeUnit i_decodeUnit (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.inValid(fsValid),
		.inWord(fsWord),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.opValid(decValid),
		.op(decOp),
		.halted(halted)
	);

	// Execute stage
	pipeStage #(
		.payloadT(decodedOpT)
	) i_execStage (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.inValid(decValid),
		.inData(decOp),
		.outValid(exValid),
		.outData(exOp)
	);

	npuExecute i_npuExecute (
		.clk(clk),
		.rst_n(rst_n),
		.opValid(exValid),
		.op(exOp),
		.npuCfgFull(npuCfgFull),
		.npuInFull(npuInFull),
		.npuOutData(npuOutData),
		.npuOutEmpty(npuOutEmpty),
		.stall(stall),
		.npuCfgData(npuCfgData),
		.npuCfgWe(npuCfgWe),
		.npuInData(npuInData),
		.npuInWe(npuInWe),
		.npuOutRe(npuOutRe),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.halt(halt)
	);

endmodule

`default_nettype wire

// ==== test/npuIssueCore_props.sv ====
// NPU issue core assertions
`timescale 1ns/1ps
`default_nettype none

module npuIssueCore_props (
	input logic clk,
	input logic rst_n,
	input logic [npuIssuePkg::addrW-1:0] instrAddr,
	input logic instrValid,
	input logic instrReady,
	input logic stall,
	input logic npuCfgWe,
	input logic npuCfgFull,
	input logic npuInWe,
	input logic npuInFull,
	input logic npuOutRe,
	input logic npuOutEmpty,
	input logic halt
);

	cfgNotFull: assert property (@(posedge clk) disable iff (!rst_n) npuCfgWe |-> !npuCfgFull)
		else $error("Configuration FIFO written while full");

	inNotFull: assert property (@(posedge clk) disable iff (!rst_n) npuInWe |-> !npuInFull)
		else $error("Input FIFO written while full");

	outNotEmpty: assert property (@(posedge clk) disable iff (!rst_n) npuOutRe |-> !npuOutEmpty)
		else $error("Output FIFO read while empty");

	haltSticky: assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt)
		else $error("Halt dropped before reset");

	haltNoFetch: assert property (@(posedge clk) disable iff (!rst_n) halt |-> !instrValid)
		else $error("Instruction request active after halt");

	// Pending request keeps its address
	addrStable: assert property (@(posedge clk) disable iff (!rst_n)
		instrValid && !(instrReady && !stall) |=> $stable(instrAddr))
		else $error("Instruction address moved without an accept");

endmodule

bind npuIssueCore npuIssueCore_props i_props (
	.clk(clk),
	.rst_n(rst_n),
	.instrAddr(instrAddr),
	.instrValid(instrValid),
	.instrReady(instrReady),
	.stall(stall),
	.npuCfgWe(npuCfgWe),
	.npuCfgFull(npuCfgFull),
	.npuInWe(npuInWe),
	.npuInFull(npuInFull),
	.npuOutRe(npuOutRe),
	.npuOutEmpty(npuOutEmpty),
	.halt(halt)
);

`default_nettype wire

// ==== test/npuIssueCore_tb.sv ====
// NPU issue core testbench
`timescale 1ns/1ps
`default_nettype none

module npuIssueCore_tb;

	import npuIssuePkg::*;

	localparam logic [31:0] bootAddr = 32'h0000_0040;
	localparam int bootIndex = 16;
	localparam int memWords = 64;
	localparam int cycleLimit = 20000;

	logic clk;
	logic rst_n;
	logic [31:0] instrAddr;
	logic instrValid;
	logic [31:0] instrData;
	logic instrReady;
	logic [31:0] npuCfgData;
	logic npuCfgWe;
	logic npuCfgFull;
	logic [31:0] npuInData;
	logic npuInWe;
	logic npuInFull;
	logic [31:0] npuOutData;
	logic npuOutEmpty;
	logic npuOutRe;
	logic halt;

	integer seed = 32'h99f3f9cd;
	int cycles = 0;

	// Instruction memory and FIFO models
	logic [31:0] mem [memWords];
	logic [31:0] prog [$];
	logic [31:0] outWords [$];
	logic [31:0] cfgSeen [$];
	logic [31:0] inSeen [$];
	int outReads;
	bit readyAlways;
	bit cfgBusy;
	bit inBusy;
	bit outBusy;

	// Reference model state kept across runs like the register file
	logic [31:0] refRegs [16];
	logic [31:0] expCfg [$];
	logic [31:0] expIn [$];
	int expReads;

	npuIssueCore #(
		.bootAddr(bootAddr)
	) i_npuIssueCore (
		.clk(clk),
		.rst_n(rst_n),
		.instrAddr(instrAddr),
		.instrValid(instrValid),
		.instrData(instrData),
		.instrReady(instrReady),
		.npuCfgData(npuCfgData),
		.npuCfgWe(npuCfgWe),
		.npuCfgFull(npuCfgFull),
		.npuInData(npuInData),
		.npuInWe(npuInWe),
		.npuInFull(npuInFull),
		.npuOutData(npuOutData),
		.npuOutEmpty(npuOutEmpty),
		.npuOutRe(npuOutRe),
		.halt(halt)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout: no finish within %0d cycles", cycleLimit);
			$display("Simulation failed");
			$fatal(1, "Run exceeded its cycle limit");
		end
	end

	function automatic logic [31:0] encode(opcodeT op, logic [3:0] rd, logic [3:0] rs,
			logic [15:0] imm);
		return {op, rd, rs, 4'h0, imm};
	endfunction

	// Config writes that would show up if ever executed
	function automatic logic [31:0] fillWord(logic [31:0] addr);
		return encode(opCfg, 4'h0, 4'h0, addr[31:16] ^ addr[15:0]);
	endfunction

	task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic driveModels();
		if (instrAddr[31:8] == '0) begin
			instrData = mem[instrAddr[7:2]];
		end else begin
			instrData = fillWord(instrAddr);
		end
		instrReady = readyAlways || (($random(seed) & 3) != 0);
		npuCfgFull = cfgBusy && (($random(seed) & 1) != 0);
		npuInFull = inBusy && (($random(seed) & 1) != 0);
		npuOutEmpty = (outWords.size() == 0) || (outBusy && (($random(seed) & 1) != 0));
		npuOutData = (outWords.size() > 0) ? outWords[0] : 32'hFFFF_FFFF;
	endtask

	task automatic recordStrobes();
		if (rst_n) begin
			if (npuCfgWe) begin
				cfgSeen.push_back(npuCfgData);
			end
			if (npuInWe) begin
				inSeen.push_back(npuInData);
			end
			if (npuOutRe) begin
				void'(outWords.pop_front());
				outReads++;
			end
		end
	endtask

	// Drive on the falling edge and sample mid low phase
	initial begin
		instrData = '0;
		instrReady = 1'b0;
		npuCfgFull = 1'b0;
		npuInFull = 1'b0;
		npuOutEmpty = 1'b1;
		npuOutData = '0;
		forever begin
			@(negedge clk);
			driveModels();
			#5;
			recordStrobes();
		end
	end

	task automatic loadProgram();
		for (int i = 0; i < memWords; i++) begin
			mem[6'(i)] = fillWord(32'(i * 4));
		end
		foreach (prog[i]) begin
			mem[6'(bootIndex + i)] = prog[i];
		end
	endtask

	// Opcodes 1 li, 2 addi, 3 cfg, 4 enq, 5 deq, 15 halt
	task automatic runReference();
		int pc;
		int nextOut;
		bit done;
		logic [31:0] w;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [31:0] imm;
		expCfg.delete();
		expIn.delete();
		pc = 0;
		nextOut = 0;
		done = 1'b0;
		while (!done && pc < prog.size()) begin
			w = prog[pc];
			rd = w[27:24];
			rs = w[23:20];
			imm = {16'h0, w[15:0]};
			case (w[31:28])
				4'd1: refRegs[rd] = imm;
				4'd2: refRegs[rd] = refRegs[rs] + imm;
				4'd3: expCfg.push_back(imm);
				4'd4: expIn.push_back(refRegs[rs]);
				4'd5: begin
					refRegs[rd] = outWords[nextOut];
					nextOut++;
				end
				4'd15: done = 1'b1;
				default: ;
			endcase
			pc++;
		end
		expReads = nextOut;
	endtask

	task automatic applyReset();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic compareRun(string name);
		checkValue({name, " cfg count"}, expCfg.size(), cfgSeen.size());
		foreach (expCfg[i]) begin
			checkValue($sformatf("%s cfg[%0d]", name, i), expCfg[i], cfgSeen[i]);
		end
		checkValue({name, " enq count"}, expIn.size(), inSeen.size());
		foreach (expIn[i]) begin
			checkValue($sformatf("%s enq[%0d]", name, i), expIn[i], inSeen[i]);
		end
		checkValue({name, " out reads"}, expReads, outReads);
	endtask

	task automatic startProgram();
		loadProgram();
		runReference();
		cfgSeen.delete();
		inSeen.delete();
		outReads = 0;
		applyReset();
	endtask

	task automatic finishProgram(string name);
		while (!halt) begin
			@(negedge clk);
		end
		compareRun(name);
	endtask

	task automatic setModes(bit ready, bit cfg, bit in, bit out);
		readyAlways = ready;
		cfgBusy = cfg;
		inBusy = in;
		outBusy = out;
	endtask

	task automatic testReset();
		setModes(1'b0, 1'b0, 1'b0, 1'b0);
		prog.delete();
		prog.push_back(encode(opCfg, 4'h0, 4'h0, 16'h005A));
		prog.push_back(encode(opHalt, 4'h0, 4'h0, 16'h0000));
		startProgram();
		checkValue("reset cfgWe", 0, 32'(npuCfgWe));
		checkValue("reset inWe", 0, 32'(npuInWe));
		checkValue("reset outRe", 0, 32'(npuOutRe));
		checkValue("reset halt", 0, 32'(halt));
		checkValue("reset instrValid", 1, 32'(instrValid));
		checkValue("reset instrAddr", bootAddr, instrAddr);
		finishProgram("reset");
	endtask

	task automatic testConfigWrites();
		logic [15:0] imms [8] = '{16'h0001, 16'hBEEF, 16'h7FFF, 16'h8000,
			16'h0000, 16'hFFFF, 16'h1234, 16'hC0DE};
		setModes(1'b0, 1'b0, 1'b0, 1'b0);
		prog.delete();
		foreach (imms[i]) begin
			prog.push_back(encode(opCfg, 4'h0, 4'h0, imms[i]));
		end
		prog.push_back(encode(opHalt, 4'h0, 4'h0, 16'h0000));
		startProgram();
		finishProgram("config writes");
	endtask

	// Back-to-back words exercise the write bypass
	task automatic testDependentArith();
		setModes(1'b1, 1'b0, 1'b0, 1'b0);
		prog.delete();
		prog.push_back(encode(opLi, 4'd1, 4'd0, 16'h1234));
		prog.push_back(encode(opAddi, 4'd1, 4'd1, 16'h0001));
		prog.push_back(encode(opAddi, 4'd2, 4'd1, 16'hFFFF));
		prog.push_back(encode(opEnq, 4'd0, 4'd2, 16'h0000));
		prog.push_back(encode(opAddi, 4'd2, 4'd2, 16'h8000));
		prog.push_back(encode(opEnq, 4'd0, 4'd2, 16'h0000));
		prog.push_back(encode(opLi, 4'd4, 4'd0, 16'hABCD));
		prog.push_back(encode(opAddi, 4'd5, 4'd4, 16'h0003));
		prog.push_back(encode(opEnq, 4'd0, 4'd5, 16'h0000));
		prog.push_back(encode(opHalt, 4'h0, 4'h0, 16'h0000));
		startProgram();
		finishProgram("dependent arith");
	endtask

	task automatic testDequeueRoundTrip();
		setModes(1'b0, 1'b0, 1'b0, 1'b1);
		outWords.delete();
		for (int i = 0; i < 5; i++) begin
			outWords.push_back(32'($random(seed)));
		end
		prog.delete();
		for (int k = 0; k < 4; k++) begin
			prog.push_back(encode(opDeq, 4'd2, 4'd0, 16'h0000));
			prog.push_back(encode(opAddi, 4'd3, 4'd2, 16'(k * 16'h0111 + 1)));
			prog.push_back(encode(opEnq, 4'd0, 4'd3, 16'h0000));
		end
		prog.push_back(encode(opHalt, 4'h0, 4'h0, 16'h0000));
		startProgram();
		finishProgram("dequeue round trip");
	endtask

	task automatic testBackPressure();
		int sel;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [15:0] imm;
		logic [31:0] freeCfg [$];
		logic [31:0] freeIn [$];
		prog.delete();
		for (int r = 1; r <= 3; r++) begin
			prog.push_back(encode(opLi, 4'(r), 4'h0, 16'(r * 16'h1111)));
		end
		for (int i = 0; i < 30; i++) begin
			sel = $random(seed) & 3;
			rd = 4'(($random(seed) & 1) + 1);
			rs = 4'(($random(seed) & 1) + 2);
			imm = 16'($random(seed));
			case (sel)
				0: prog.push_back(encode(opLi, rd, 4'h0, imm));
				1: prog.push_back(encode(opAddi, rd, rs, imm));
				2: prog.push_back(encode(opCfg, 4'h0, 4'h0, imm));
				default: prog.push_back(encode(opEnq, 4'h0, rs, 16'h0000));
			endcase
		end
		prog.push_back(encode(opHalt, 4'h0, 4'h0, 16'h0000));
		setModes(1'b0, 1'b0, 1'b0, 1'b0);
		startProgram();
		finishProgram("stall free");
		freeCfg = cfgSeen;
		freeIn = inSeen;
		setModes(1'b0, 1'b1, 1'b1, 1'b0);
		startProgram();
		finishProgram("back pressure");
		checkValue("back pressure cfg runs", freeCfg.size(), cfgSeen.size());
		foreach (freeCfg[i]) begin
			checkValue($sformatf("back pressure cfg run[%0d]", i), freeCfg[i], cfgSeen[i]);
		end
		checkValue("back pressure enq runs", freeIn.size(), inSeen.size());
		foreach (freeIn[i]) begin
			checkValue($sformatf("back pressure enq run[%0d]", i), freeIn[i], inSeen[i]);
		end
	endtask

	task automatic testHalt();
		setModes(1'b0, 1'b0, 1'b0, 1'b0);
		outWords.delete();
		outWords.push_back(32'h0F0F_1234);
		prog.delete();
		prog.push_back(encode(opLi, 4'd1, 4'd0, 16'h55AA));
		prog.push_back(encode(opEnq, 4'd0, 4'd1, 16'h0000));
		prog.push_back(encode(opHalt, 4'h0, 4'h0, 16'h0000));
		prog.push_back(encode(opLi, 4'd1, 4'd0, 16'h0BAD));
		prog.push_back(encode(opCfg, 4'h0, 4'h0, 16'h0BAD));
		prog.push_back(encode(opEnq, 4'd0, 4'd1, 16'h0000));
		prog.push_back(encode(opDeq, 4'd4, 4'd0, 16'h0000));
		startProgram();
		finishProgram("halt");
		repeat (20) begin
			@(negedge clk);
			checkValue("halt held", 1, 32'(halt));
			checkValue("halt instrValid", 0, 32'(instrValid));
		end
		compareRun("halt quiet");
		// r1 must still hold the value from before the HALT
		prog.delete();
		prog.push_back(encode(opEnq, 4'd0, 4'd1, 16'h0000));
		prog.push_back(encode(opHalt, 4'h0, 4'h0, 16'h0000));
		startProgram();
		finishProgram("halt register");
	endtask

	initial begin
		rst_n = 1'b0;
		setModes(1'b0, 1'b0, 1'b0, 1'b0);
		testReset();
		testConfigWrites();
		testDependentArith();
		testDequeueRoundTrip();
		testBackPressure();
		testHalt();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
source/npuIssuePkg.sv
source/instrFetch.sv
source/pipeStage.sv
source/decodeUnit.sv
source/npuExecute.sv
source/npuIssueCore.sv
test/npuIssueCore_props.sv
test/npuIssueCore_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the NPU issue core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module npuIssueCore_tb -f flist.f -o simv &&
./obj_dir/simv || exit 1
